/* logic/mem_isa_pkg.sv */
package mem_isa_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Destination register index
    localparam int REG_ADDR_W = 5;

    // Data memory geometry
    // Four word interleaved banks
    localparam int NUM_BANKS = 4;
    localparam int BANK_SEL_W = 2;
    localparam int ROW_W = 6;
    localparam int BANK_ROWS = 64;

    // Byte address bit positions
    // Bits 1:0 are the byte offset and are ignored for whole word access
    localparam int BANK_LSB = 2;
    localparam int ROW_LSB = BANK_LSB + BANK_SEL_W;

    // Width of the operation kind field
    localparam int OP_W = 3;

    // What the memory stage does with an operation
    typedef enum logic [OP_W-1:0] {
        // Write back the ALU result
        ALU   = 3'd0,
        // Write back the immediate
        LUI   = 3'd1,
        // Write back the link address
        JAL   = 3'd2,
        // Write back the memory word
        LOAD  = 3'd3,
        // Memory write only, nothing for the register file
        STORE = 3'd4
    } mem_op_e;

endpackage

/* logic/mem_pipe_pkg.sv */
package mem_pipe_pkg;

    import mem_isa_pkg::*;

    // Input queue from execute
    localparam int EXMEM_DEPTH = 2;
    localparam int EXMEM_PTR_W = $clog2(EXMEM_DEPTH);
    localparam int EXMEM_CNT_W = $clog2(EXMEM_DEPTH + 1);

    // Result queue toward writeback
    localparam int MEMWB_DEPTH = 4;
    localparam int MEMWB_PTR_W = $clog2(MEMWB_DEPTH);
    localparam int MEMWB_CNT_W = $clog2(MEMWB_DEPTH + 1);

    // Credits granted by writeback at reset
    localparam int WB_CREDITS = 4;
    localparam int WB_CRED_W = $clog2(WB_CREDITS + 1);

    // One operation handed over by execute
    typedef struct packed {
        mem_op_e               op;
        // Effective address for LOAD and STORE, result otherwise
        logic [XLEN-1:0]       alu_out;
        // Store operand from the register file
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       imm;
        // PC+4 for JAL
        logic [XLEN-1:0]       pc_inc;
        logic [REG_ADDR_W-1:0] rd;
        // Take store data from writeback instead of store_data
        logic                  wb_forward;
    } exmem_t;

    // One finished result for writeback
    typedef struct packed {
        mem_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        // Zero for STORE
        logic [XLEN-1:0]       result;
    } memwb_t;

endpackage

/* logic/exmem_queue.sv */
module exmem_queue import mem_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  exmem_t in_op,
    output logic   in_credit,
    output logic   head_valid,
    output exmem_t head_op,
    input  logic   issue
);

    // Entry storage
    exmem_t mem [EXMEM_DEPTH];

    logic [EXMEM_PTR_W-1:0] wr_ptr;
    logic [EXMEM_PTR_W-1:0] rd_ptr;
    logic [EXMEM_CNT_W-1:0] count;

    // Upstream only sends while holding a credit, so a push always finds a slot
    logic push;
    logic pop;

    assign push = in_valid;
    assign pop  = issue;

    // Oldest entry is offered to the access logic
    assign head_valid = (count != '0);
    assign head_op    = mem[rd_ptr];

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_op;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own at a power of two depth
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back to execute per freed slot
    // Sent the cycle after the pop once the slot is really free
    always_ff @(posedge clk) begin
        if (rst) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;
        end
    end

endmodule

/* logic/dmem_bank.sv */
module dmem_bank import mem_isa_pkg::*; (
    input  logic             clk,
    input  logic             we,
    input  logic             re,
    input  logic [ROW_W-1:0] row,
    input  logic [XLEN-1:0]  wdata,
    output logic [XLEN-1:0]  rdata
);

    // One word per row
    // Contents stay undefined until first written
    logic [XLEN-1:0] mem [BANK_ROWS];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[row] <= wdata;
        end
    end

    // Registered read, data valid the cycle after re
    // Output holds the last read word while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[row];
        end
    end

endmodule

/* logic/mem_access.sv */
module mem_access
    import mem_isa_pkg::*;
    import mem_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            head_valid,
    input  exmem_t          head_op,
    input  logic            room,
    input  logic [XLEN-1:0] wb_data,
    output logic            issue,
    output logic            res_valid,
    output memwb_t          res
);

    // Address decode of the head operation
    logic [BANK_SEL_W-1:0] bank_sel;
    logic [ROW_W-1:0]      row;

    // Per bank strobes and shared write data
    logic [NUM_BANKS-1:0]  bank_we;
    logic [NUM_BANKS-1:0]  bank_re;
    logic [XLEN-1:0]       store_wdata;
    logic [XLEN-1:0]       bank_rdata [NUM_BANKS];

    // Result of anything that is not a load
    logic [XLEN-1:0]       reg_result;

    // Registered half of the result
    memwb_t                res_q;
    logic [BANK_SEL_W-1:0] bank_q;

    // Only move when the result queue can take what comes out
    assign issue = head_valid && room;

    // Word interleaved with bits 3:2 picking the bank and 9:4 the row
    assign bank_sel = head_op.alu_out[BANK_LSB +: BANK_SEL_W];
    assign row      = head_op.alu_out[ROW_LSB +: ROW_W];

    // Forwarded writeback value wins over the register operand
    assign store_wdata = head_op.wb_forward ? wb_data : head_op.store_data;

    // Strobe only the addressed bank
    always_comb begin
        bank_we = '0;
        bank_re = '0;
        if (issue) begin
            if (head_op.op == STORE) begin
                bank_we[bank_sel] = 1'b1;
            end
            if (head_op.op == LOAD) begin
                bank_re[bank_sel] = 1'b1;
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dmem_bank i_dmem_bank (
            .clk   (clk),
            .we    (bank_we[b]),
            .re    (bank_re[b]),
            .row   (row),
            .wdata (store_wdata),
            .rdata (bank_rdata[b])
        );
    end

    // Register result by kind
    always_comb begin
        case (head_op.op)
            JAL:     reg_result = head_op.pc_inc;
            LUI:     reg_result = head_op.imm;
            ALU:     reg_result = head_op.alu_out;
            // STORE has nothing to write back and LOAD fills in later
            default: reg_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

    // Payload follows issue
    always_ff @(posedge clk) begin
        if (issue) begin
            res_q.op     <= head_op.op;
            res_q.rd     <= head_op.rd;
            res_q.result <= reg_result;
            bank_q       <= bank_sel;
        end
    end

    // Load data arrives from the bank one cycle after issue
    always_comb begin
        res = res_q;
        if (res_q.op == LOAD) begin
            res.result = bank_rdata[bank_q];
        end
    end

endmodule

/* logic/memwb_queue.sv */
module memwb_queue import mem_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   res_valid,
    input  memwb_t res,
    output logic   room,
    output logic   out_valid,
    output memwb_t out_res,
    input  logic   out_credit
);

    // Result storage
    memwb_t mem [MEMWB_DEPTH];

    logic [MEMWB_PTR_W-1:0] wr_ptr;
    logic [MEMWB_PTR_W-1:0] rd_ptr;
    logic [MEMWB_CNT_W-1:0] count;

    // Writeback credits held
    logic [WB_CRED_W-1:0]   credits;

    // Stored entries plus the one result still in mem_access
    logic [MEMWB_CNT_W:0]   occupancy;

    logic push;
    logic send;

    assign push = res_valid;

    // A credit means writeback has a slot, so presenting is sending
    assign out_valid = (count != '0) && (credits != '0);
    assign send      = out_valid;
    assign out_res   = mem[rd_ptr];

    assign occupancy = {1'b0, count} + {{MEMWB_CNT_W{1'b0}}, res_valid};

    // Issue is allowed only if its result will still fit next cycle
    assign room = (occupancy < (MEMWB_CNT_W + 1)'(MEMWB_DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= res;
        end
    end

    // Queue state
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credit counter
    // Spend and return in one cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= WB_CRED_W'(WB_CREDITS);
        end else begin
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* logic/mem_stage_top.sv */
module mem_stage_top
    import mem_isa_pkg::*;
    import mem_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  exmem_t          in_op,
    output logic            in_credit,
    input  logic [XLEN-1:0] wb_data,
    output logic            out_valid,
    output memwb_t          out_res,
    input  logic            out_credit
);

    // Input queue head
    logic   head_valid;
    exmem_t head_op;
    logic   issue;

    // Back-pressure from the result queue
    logic   room;

    // Access result, one cycle after issue
    logic   res_valid;
    memwb_t res;

    exmem_queue i_exmem_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .head_valid (head_valid),
        .head_op    (head_op),
        .issue      (issue)
    );

    mem_access i_mem_access (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head_op    (head_op),
        .room       (room),
        .wb_data    (wb_data),
        .issue      (issue),
        .res_valid  (res_valid),
        .res        (res)
    );

    memwb_queue i_memwb_queue (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (res),
        .room       (room),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

endmodule

/* test/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 10;
    localparam int RESET_CYCLES = 3;

    // Free running clock starting low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* test/mem_stage_tb.sv */
module mem_stage_tb
    import mem_isa_pkg::*;
    import mem_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_OPS     = 200;
    // Enough to fill both queues and use up every writeback credit
    localparam int BP_OPS         = EXMEM_DEPTH + MEMWB_DEPTH + WB_CREDITS;
    localparam int MEM_WORDS      = NUM_BANKS * BANK_ROWS;
    localparam int IDX_W          = BANK_SEL_W + ROW_W;

    logic            clk;
    logic            rst;
    logic            in_valid;
    exmem_t          in_op;
    logic            in_credit;
    logic [XLEN-1:0] wb_data;
    logic            out_valid;
    memwb_t          out_res;
    logic            out_credit = 1'b0;

    // Expected results in program order
    memwb_t          sb [$];
    memwb_t          exp_res;

    // Reference data memory, indexed by word address bits 9:2
    logic [XLEN-1:0] model_mem [MEM_WORDS];
    bit              written [MEM_WORDS];

    // Cycle numbers at which writeback hands a credit back
    int              credit_due [$];

    // Sender credits and the DUT's writeback credits as seen from outside
    int              ex_credits;
    int              wb_held;
    int              cycle = 0;

    int              outputs_seen = 0;
    int              credit_pulses = 0;
    int              mismatch_errors = 0;
    int              protocol_errors = 0;
    int              unexpected_errors = 0;

    logic            withhold = 1'b0;
    logic            first_sent = 1'b0;
    string           test_name = "reset_idle";

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    mem_stage_top i_mem_stage_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .wb_data    (wb_data),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    // Byte address of one word with the bank in bits 3:2 and the row above
    function automatic logic [XLEN-1:0] word_addr(input int row, input int bank);
        return (XLEN'(row) << ROW_LSB) | (XLEN'(bank) << BANK_LSB);
    endfunction

    function automatic exmem_t build_op(
        input mem_op_e               kind,
        input logic [XLEN-1:0]       alu_out,
        input logic [XLEN-1:0]       store_data,
        input logic [XLEN-1:0]       imm,
        input logic [XLEN-1:0]       pc_inc,
        input logic [REG_ADDR_W-1:0] rd,
        input logic                  fwd
    );
        exmem_t o;
        o.op         = kind;
        o.alu_out    = alu_out;
        o.store_data = store_data;
        o.imm        = imm;
        o.pc_inc     = pc_inc;
        o.rd         = rd;
        o.wb_forward = fwd;
        return o;
    endfunction

    // Reference behavior of the stage, applied in program order
    function automatic memwb_t expected_result(input exmem_t op);
        memwb_t           r;
        logic [IDX_W-1:0] idx;
        idx      = op.alu_out[BANK_LSB +: IDX_W];
        r.op     = op.op;
        r.rd     = op.rd;
        r.result = '0;
        case (op.op)
            ALU:  r.result = op.alu_out;
            LUI:  r.result = op.imm;
            JAL:  r.result = op.pc_inc;
            LOAD: r.result = model_mem[idx];
            default: begin
                // Store result stays zero
                model_mem[idx] = op.wb_forward ? wb_data : op.store_data;
                written[idx]   = 1'b1;
            end
        endcase
        return r;
    endfunction

    function automatic exmem_t random_op();
        exmem_t          o;
        logic [OP_W-1:0] kind;
        kind         = OP_W'($urandom_range(0, 4));
        o.op         = mem_op_e'(kind);
        o.alu_out    = $urandom();
        o.store_data = $urandom();
        o.imm        = $urandom();
        o.pc_inc     = $urandom();
        o.rd         = REG_ADDR_W'($urandom());
        o.wb_forward = 1'($urandom_range(0, 1));
        // Rows 0 to 3 only so loads often hit earlier stores
        if (o.op == LOAD || o.op == STORE) begin
            o.alu_out[9:6] = '0;
        end
        // Never load a word that was not written
        if (o.op == LOAD && !written[o.alu_out[BANK_LSB +: IDX_W]]) begin
            o.op = STORE;
        end
        return o;
    endfunction

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic send_op(input exmem_t op);
        while (ex_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid   = 1'b1;
        in_op      = op;
        first_sent = 1'b1;
        sb.push_back(expected_result(op));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Wait until every expected result has come out
    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (sb.size() != 0);
        #1;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            mismatch_errors++;
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // Credit mirrors updated from the values of the closing cycle
    always @(posedge clk) begin
        if (rst) begin
            ex_credits <= EXMEM_DEPTH;
            wb_held    <= WB_CREDITS;
        end else begin
            ex_credits <= ex_credits + int'(in_credit) - int'(in_valid);
            wb_held    <= wb_held - int'(out_valid) + int'(out_credit);
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Writeback side sampled at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                credit_pulses++;
            end
            if (out_valid) begin
                outputs_seen++;
                credit_due.push_back(cycle + int'($urandom_range(0, 3)));
                assert (sb.size() != 0) else begin
                    unexpected_errors++;
                    $display("Unexpected result with no operation pending in %s", test_name);
                end
                if (sb.size() != 0) begin
                    exp_res = sb.pop_front();
                    assert (out_res == exp_res) else begin
                        mismatch_errors++;
                        $display("Mismatch in %s: expected %s rd %0d %h, actual %s rd %0d %h",
                                 test_name, exp_res.op.name(), exp_res.rd, exp_res.result,
                                 out_res.op.name(), out_res.rd, out_res.result);
                    end
                end
            end
        end
    end

    // Credit return pulses stop while withheld
    always @(posedge clk) begin
        #1;
        if (!withhold && credit_due.size() != 0 && credit_due[0] <= cycle) begin
            out_credit = 1'b1;
            void'(credit_due.pop_front());
        end else begin
            out_credit = 1'b0;
        end
    end

    // Returned input credits never exceed the queue depth
    sender_credit: assert property (@(negedge clk) disable iff (rst)
        ex_credits <= EXMEM_DEPTH && (!in_valid || ex_credits > 0))
    else begin
        protocol_errors++;
        $display("Protocol error: input credits above queue depth or in_valid sent with none");
    end

    output_credit: assert property (@(negedge clk) disable iff (rst)
        out_valid |-> wb_held > 0)
    else begin
        protocol_errors++;
        $display("Protocol error: out_valid asserted while holding no writeback credit");
    end

    // Nothing moves before the first operation
    idle_after_reset: assert property (@(negedge clk) disable iff (rst)
        !first_sent |-> !out_valid && !in_credit)
    else begin
        protocol_errors++;
        $display("Protocol error: out_valid or in_credit high before any operation");
    end

    initial begin
        int base_outputs;
        int held_outputs;
        int base_pulses;
        void'($urandom(19));
        in_valid = 1'b0;
        in_op    = '0;
        wb_data  = '0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // Idle a few cycles after reset
        repeat (5) @(posedge clk);
        #1;

        test_name = "alu_lui_jal";
        send_op(build_op(ALU, 32'h1234_5678, '0, 32'hdead_0000, 32'h0000_0044, 5'd3, 1'b0));
        send_op(build_op(LUI, 32'h0000_0010, '0, 32'habcd_e000, 32'h0000_0048, 5'd7, 1'b0));
        send_op(build_op(JAL, 32'h0000_0020, '0, 32'h0000_0800, 32'h0000_0104, 5'd1, 1'b0));
        wait_drain();

        // Same row in every bank plus a neighbour row
        test_name = "bank_interleave";
        for (int b = 0; b < NUM_BANKS; b++) begin
            send_op(build_op(STORE, word_addr(5, b), 32'h5a00_0000 | XLEN'(b), '0, '0,
                             5'd0, 1'b0));
        end
        send_op(build_op(STORE, word_addr(6, 1), 32'h6b6b_0001, '0, '0, 5'd0, 1'b0));
        for (int b = 0; b < NUM_BANKS; b++) begin
            send_op(build_op(LOAD, word_addr(5, b), '0, '0, '0, REG_ADDR_W'(b + 8), 1'b0));
        end
        send_op(build_op(LOAD, word_addr(6, 1), '0, '0, '0, 5'd20, 1'b0));
        wait_drain();

        // Forwarded value must replace the register operand
        test_name = "store_forward";
        wb_data   = 32'hcafe_f00d;
        send_op(build_op(STORE, word_addr(9, 3), 32'h1111_1111, '0, '0, 5'd0, 1'b1));
        send_op(build_op(LOAD, word_addr(9, 3), '0, '0, '0, 5'd12, 1'b0));
        wait_drain();

        test_name = "random_mix";
        wb_data   = $urandom();
        for (int i = 0; i < RANDOM_OPS; i++) begin
            send_op(random_op());
        end
        wait_drain();

        // Start with every writeback credit back home
        test_name = "backpressure";
        do begin
            @(posedge clk);
        end while (wb_held != WB_CREDITS);
        #1;
        withhold     = 1'b1;
        base_outputs = outputs_seen;
        for (int i = 0; i < BP_OPS; i++) begin
            send_op(build_op(ALU, 32'h0000_b000 + XLEN'(i), '0, '0, '0, 5'd9, 1'b0));
        end
        repeat (10) @(posedge clk);
        #1;
        base_pulses  = credit_pulses;
        held_outputs = outputs_seen;
        repeat (20) @(posedge clk);
        #1;
        check_value("results while held", WB_CREDITS, outputs_seen - base_outputs);
        check_value("results in hold window", 0, outputs_seen - held_outputs);
        check_value("input credits in hold window", 0, credit_pulses - base_pulses);
        check_value("sender credits left", 0, ex_credits);
        withhold = 1'b0;
        wait_drain();
        check_value("results after release", BP_OPS, outputs_seen - base_outputs);

        $display("Summary: %0d mismatches, %0d protocol errors, %0d unexpected results, %0d checked",
                 mismatch_errors, protocol_errors, unexpected_errors, outputs_seen);
        if (mismatch_errors + protocol_errors + unexpected_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/mem_isa_pkg.sv
logic/mem_pipe_pkg.sv
logic/exmem_queue.sv
logic/dmem_bank.sv
logic/mem_access.sv
logic/memwb_queue.sv
logic/mem_stage_top.sv
test/tb_clock.sv
test/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f sim.f \
    --top-module mem_stage_tb -o mem_stage_sim || exit 1

out=$(./obj_dir/mem_stage_sim)
echo "$out"

echo "$out" | grep -q 'All tests passed!' && echo "Simulation PASSED" || {
    echo "Simulation FAILED"
    exit 1
}
